// File: src/xgmii_pkg.sv
// XGMII receive word struct and control character codes
package xgmii_pkg;

    // One 64-bit receive word, control flag per byte
    typedef struct packed {
        logic [63:0] d;
        logic [7:0]  c;
    } xgmii_word_t;

    // Control characters, valid only where the matching c bit is set
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_TERM  = 8'hfd;
    localparam logic [7:0] XGMII_ERROR = 8'hfe;

endpackage

// File: src/qsfp_status_pkg.sv
// Lane and link statistics structs, APB request/response structs and register map
package qsfp_status_pkg;

    // Per-lane frame monitor results
    typedef struct packed {
        logic [15:0] frame_count;
        logic [15:0] error_count;
        logic        frame_seen;
        logic        error_seen;
    } lane_stats_t;

    // Per-lane link health results
    typedef struct packed {
        logic       link_up;
        logic [7:0] drop_count;
    } link_stats_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [8:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Global registers
    localparam logic [8:0] REG_CTRL        = 9'h000;
    localparam logic [8:0] REG_LINK        = 9'h004;

    // Lane register blocks
    localparam logic [8:0] REG_LANE_BASE   = 9'h010;
    localparam logic [8:0] REG_LANE_STRIDE = 9'h010;

    // Offsets inside one lane block
    localparam logic [8:0] REG_FRAMES      = 9'h000;
    localparam logic [8:0] REG_ERRORS      = 9'h004;
    localparam logic [8:0] REG_DROPS       = 9'h008;

endpackage

// File: src/xgmii_frame_monitor.sv
// Per-lane XGMII decoder with saturating frame start and error counters
`timescale 1ns/1ps

module xgmii_frame_monitor (
    input  logic                         clk,
    input  logic                         reset,
    input  xgmii_pkg::xgmii_word_t       rx_word,
    input  logic                         stats_clear,
    output qsfp_status_pkg::lane_stats_t stats
);

    import xgmii_pkg::*;

    logic start_hit;
    logic error_hit;

    // Start can only be aligned to lane 0 or lane 4 of the 64-bit word
    assign start_hit = (rx_word.c[0] && (rx_word.d[7:0] == XGMII_START)) ||
                       (rx_word.c[4] && (rx_word.d[39:32] == XGMII_START));

    // Any flagged error byte, counted once per word
    always_comb begin
        error_hit = 1'b0;
        for (int b = 0; b < 8; b++) begin
            if (rx_word.c[b] && (rx_word.d[8*b +: 8] == XGMII_ERROR)) begin
                error_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || stats_clear) begin
            // Word on the clear edge is dropped
            stats.frame_count <= '0;
            stats.error_count <= '0;
            stats.frame_seen  <= 1'b0;
            stats.error_seen  <= 1'b0;
        end else begin
            stats.frame_seen <= start_hit;
            stats.error_seen <= error_hit;
            if (start_hit && (stats.frame_count != '1)) begin
                stats.frame_count <= stats.frame_count + 16'd1;
            end
            if (error_hit && (stats.error_count != '1)) begin
                stats.error_count <= stats.error_count + 16'd1;
            end
        end
    end

endmodule

// File: src/link_health.sv
// Per-lane block lock qualification and saturating link drop counter
`timescale 1ns/1ps

module link_health #(
    parameter int LOCK_CYCLES = 16
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         block_lock,
    input  logic                         stats_clear,
    output qsfp_status_pkg::link_stats_t stats
);

    localparam int RUN_W = $clog2(LOCK_CYCLES + 1);

    // Consecutive edges with block lock seen
    logic [RUN_W-1:0] run_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            run_cnt       <= '0;
            stats.link_up <= 1'b0;
        end else if (!block_lock) begin
            run_cnt       <= '0;
            stats.link_up <= 1'b0;
        end else if (run_cnt == RUN_W'(LOCK_CYCLES - 1)) begin
            // Lock held for LOCK_CYCLES edges including this one
            stats.link_up <= 1'b1;
        end else begin
            run_cnt <= run_cnt + 1'b1;
        end
    end

    // Drop counted on the edge that takes link_up low
    always_ff @(posedge clk) begin
        if (reset || stats_clear) begin
            stats.drop_count <= '0;
        end else if (stats.link_up && !block_lock && (stats.drop_count != '1)) begin
            stats.drop_count <= stats.drop_count + 8'd1;
        end
    end

endmodule

// File: src/qsfp_status_regs.sv
// APB status register file, counter clear pulse and QSFP LED drivers
`timescale 1ns/1ps

module qsfp_status_regs #(
    parameter int NUM_LANES = 4,
    parameter int ACT_HOLD  = 64
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  qsfp_status_pkg::apb_req_t                    apb_req,
    output qsfp_status_pkg::apb_rsp_t                    apb_rsp,
    input  qsfp_status_pkg::lane_stats_t [NUM_LANES-1:0] lane_stats,
    input  qsfp_status_pkg::link_stats_t [NUM_LANES-1:0] link_stats,
    output logic                                         stats_clear,
    output logic                                         qsfp_led_act,
    output logic                                         qsfp_led_stat_g,
    output logic                                         qsfp_led_stat_y
);

    import qsfp_status_pkg::*;

    localparam int ACT_W = $clog2(ACT_HOLD + 1);

    logic             access;
    logic             any_frame;
    logic             any_error;
    logic             all_up;
    logic [ACT_W-1:0] act_cnt;

    assign access = apb_req.psel && apb_req.penable;

    // Zero wait state read decode, counters as registered now
    always_comb begin
        logic [8:0] lane_addr;
        logic       mapped;
        apb_rsp        = '0;
        apb_rsp.pready = 1'b1;
        mapped = (apb_req.paddr == REG_CTRL) || (apb_req.paddr == REG_LINK);
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_addr = REG_LANE_BASE + 9'(i) * REG_LANE_STRIDE;
            if (apb_req.paddr == REG_LINK) begin
                apb_rsp.prdata[i] = link_stats[i].link_up;
            end
            if (apb_req.paddr == lane_addr + REG_FRAMES) begin
                mapped         = 1'b1;
                apb_rsp.prdata = 32'(lane_stats[i].frame_count);
            end
            if (apb_req.paddr == lane_addr + REG_ERRORS) begin
                mapped         = 1'b1;
                apb_rsp.prdata = 32'(lane_stats[i].error_count);
            end
            if (apb_req.paddr == lane_addr + REG_DROPS) begin
                mapped         = 1'b1;
                apb_rsp.prdata = 32'(link_stats[i].drop_count);
            end
        end
        // Only REG_CTRL is writable
        apb_rsp.pslverr = access &&
                          (!mapped || (apb_req.pwrite && (apb_req.paddr != REG_CTRL)));
    end

    // Clear pulse for the cycle after the write access
    always_ff @(posedge clk) begin
        if (reset) begin
            stats_clear <= 1'b0;
        end else begin
            stats_clear <= access && apb_req.pwrite &&
                           (apb_req.paddr == REG_CTRL) && apb_req.pwdata[0];
        end
    end

    // Lane summaries for the LEDs
    always_comb begin
        any_frame = 1'b0;
        any_error = 1'b0;
        all_up    = 1'b1;
        for (int i = 0; i < NUM_LANES; i++) begin
            any_frame = any_frame | lane_stats[i].frame_seen;
            any_error = any_error | (lane_stats[i].error_count != '0);
            all_up    = all_up & link_stats[i].link_up;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            qsfp_led_stat_g <= 1'b0;
            qsfp_led_stat_y <= 1'b0;
        end else begin
            qsfp_led_stat_g <= all_up;
            qsfp_led_stat_y <= any_error;
        end
    end

    // Activity stretch, ACT_HOLD cycles from the last frame start
    always_ff @(posedge clk) begin
        if (reset) begin
            act_cnt      <= '0;
            qsfp_led_act <= 1'b0;
        end else if (any_frame) begin
            act_cnt      <= ACT_W'(ACT_HOLD - 1);
            qsfp_led_act <= 1'b1;
        end else if (act_cnt != '0) begin
            act_cnt <= act_cnt - 1'b1;
        end else begin
            qsfp_led_act <= 1'b0;
        end
    end

endmodule

// File: src/qsfp_status_core.sv
// QSFP status core top level with per-lane monitors and the register block
`timescale 1ns/1ps

module qsfp_status_core #(
    parameter int NUM_LANES   = 4,
    parameter int LOCK_CYCLES = 16,
    parameter int ACT_HOLD    = 64
) (
    input  logic                                   clk,
    input  logic                                   reset,

    // Per-lane receive side, already in the core clock domain
    input  xgmii_pkg::xgmii_word_t [NUM_LANES-1:0] rx_word,
    input  logic [NUM_LANES-1:0]                   block_lock,

    // Register access
    input  qsfp_status_pkg::apb_req_t              apb_req,
    output qsfp_status_pkg::apb_rsp_t              apb_rsp,

    // Front panel
    output logic                                   qsfp_led_act,
    output logic                                   qsfp_led_stat_g,
    output logic                                   qsfp_led_stat_y
);

    import qsfp_status_pkg::*;

    lane_stats_t [NUM_LANES-1:0] lane_stats;
    link_stats_t [NUM_LANES-1:0] link_stats;
    logic                        stats_clear;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        xgmii_frame_monitor frame_monitor_inst (
            .clk         (clk),
            .reset       (reset),
            .rx_word     (rx_word[i]),
            .stats_clear (stats_clear),
            .stats       (lane_stats[i])
        );

        link_health #(
            .LOCK_CYCLES (LOCK_CYCLES)
        ) link_health_inst (
            .clk         (clk),
            .reset       (reset),
            .block_lock  (block_lock[i]),
            .stats_clear (stats_clear),
            .stats       (link_stats[i])
        );
    end

    qsfp_status_regs #(
        .NUM_LANES (NUM_LANES),
        .ACT_HOLD  (ACT_HOLD)
    ) status_regs_inst (
        .clk             (clk),
        .reset           (reset),
        .apb_req         (apb_req),
        .apb_rsp         (apb_rsp),
        .lane_stats      (lane_stats),
        .link_stats      (link_stats),
        .stats_clear     (stats_clear),
        .qsfp_led_act    (qsfp_led_act),
        .qsfp_led_stat_g (qsfp_led_stat_g),
        .qsfp_led_stat_y (qsfp_led_stat_y)
    );

endmodule

// File: tests/qsfp_status_model.svh
// Expected counter and link state, XGMII decode and register read reference functions
`ifndef QSFP_STATUS_MODEL_SVH
`define QSFP_STATUS_MODEL_SVH

int unsigned exp_frames [NUM_LANES];
int unsigned exp_errors [NUM_LANES];
int unsigned exp_drops  [NUM_LANES];
int unsigned lock_run   [NUM_LANES];
bit          exp_link   [NUM_LANES];

typedef struct packed {
    logic [31:0] data;
    logic        err;
} apb_exp_t;

// Start counts only in byte 0 or byte 4 and only with its control flag
function automatic bit is_start(xgmii_word_t w);
    return (w.c[0] && (w.d[7:0] == XGMII_START)) || (w.c[4] && (w.d[39:32] == XGMII_START));
endfunction

function automatic bit has_error(xgmii_word_t w);
    for (int b = 0; b < 8; b++) begin
        if (w.c[b] && (w.d[8*b +: 8] == XGMII_ERROR)) return 1'b1;
    end
    return 1'b0;
endfunction

// One clock edge of one lane
function automatic void update_lane(int i, xgmii_word_t w, bit lock, bit clr);
    if (clr) begin
        exp_frames[i] = 0;
        exp_errors[i] = 0;
        exp_drops[i]  = 0;
    end else begin
        if (is_start(w) && (exp_frames[i] < 32'hffff)) exp_frames[i]++;
        if (has_error(w) && (exp_errors[i] < 32'hffff)) exp_errors[i]++;
        if (!lock && exp_link[i] && (exp_drops[i] < 32'hff)) exp_drops[i]++;
    end
    // Link qualification ignores the counter clear
    if (!lock) begin
        lock_run[i] = 0;
    end else if (lock_run[i] < LOCK_CYCLES) begin
        lock_run[i]++;
    end
    exp_link[i] = (lock_run[i] >= LOCK_CYCLES);
endfunction

function automatic apb_exp_t expected_read(logic [8:0] addr);
    apb_exp_t    r;
    int unsigned lane;
    int unsigned offset;
    r = '0;
    if (addr == REG_LINK) begin
        for (int i = 0; i < NUM_LANES; i++) r.data[i] = exp_link[i];
    end else if (addr != REG_CTRL) begin
        r.err = 1'b1;
        if (addr >= REG_LANE_BASE) begin
            lane   = (addr - REG_LANE_BASE) / REG_LANE_STRIDE;
            offset = (addr - REG_LANE_BASE) % REG_LANE_STRIDE;
            if (lane < NUM_LANES) begin
                r.err = 1'b0;
                case (offset)
                    REG_FRAMES: r.data = exp_frames[lane];
                    REG_ERRORS: r.data = exp_errors[lane];
                    REG_DROPS:  r.data = exp_drops[lane];
                    default:    r.err = 1'b1;
                endcase
            end
        end
    end
    return r;
endfunction

`endif

// File: tests/tb_qsfp_status_core.sv
// Testbench for the QSFP status core with stimulus, APB tasks, model comparison and watchdog
`timescale 1ns/1ps

module tb_qsfp_status_core;

    import xgmii_pkg::*;
    import qsfp_status_pkg::*;

    localparam int NUM_LANES   = 4;
    localparam int LOCK_CYCLES = 16;
    localparam int ACT_HOLD    = 64;
    localparam int WORDS       = 400;
    localparam int WALK        = 600;
    // All phases in clock cycles
    localparam int TEST_CYCLES = 10 + WORDS * 5 / 4 + WALK + 8 * LOCK_CYCLES + 4 * ACT_HOLD
                                 + 8 * 2 * (2 + 3 * NUM_LANES) + 50;
    localparam xgmii_word_t IDLE_WORD = '{d: {8{XGMII_IDLE}}, c: 8'hff};
    localparam logic [5:0][8:0] BAD_ADDR = {9'h008, 9'h00c, 9'h011, 9'h01c, 9'h050, 9'h1fc};

    typedef struct packed {
        logic        write;
        logic [8:0]  addr;
        logic [31:0] data;
        logic        slverr;
        logic        ready;
    } apb_obs_t;

    logic                        clk = 1'b0;
    logic                        reset;
    xgmii_word_t [NUM_LANES-1:0] rx_word;
    logic [NUM_LANES-1:0]        block_lock;
    apb_req_t                    apb_req;
    apb_rsp_t                    apb_rsp;
    logic                        qsfp_led_act;
    logic                        qsfp_led_stat_g;
    logic                        qsfp_led_stat_y;
    bit                          clear_due;
    apb_obs_t                    obs_q [$];
    event                        obs_ready;

    `include "qsfp_status_model.svh"

    qsfp_status_core #(
        .NUM_LANES   (NUM_LANES),
        .LOCK_CYCLES (LOCK_CYCLES),
        .ACT_HOLD    (ACT_HOLD)
    ) qsfp_status_core_i (
        .clk             (clk),
        .reset           (reset),
        .rx_word         (rx_word),
        .block_lock      (block_lock),
        .apb_req         (apb_req),
        .apb_rsp         (apb_rsp),
        .qsfp_led_act    (qsfp_led_act),
        .qsfp_led_stat_g (qsfp_led_stat_g),
        .qsfp_led_stat_y (qsfp_led_stat_y)
    );

    always #4 clk = ~clk;

    // Model steps on every rising edge
    // Clear takes effect one edge after the write access
    always @(posedge clk) begin
        bit clr;
        clr = clear_due;
        clear_due = !reset && apb_req.psel && apb_req.penable && apb_req.pwrite &&
                    (apb_req.paddr == REG_CTRL) && apb_req.pwdata[0];
        for (int i = 0; i < NUM_LANES; i++) begin
            update_lane(i, rx_word[i], block_lock[i] && !reset, clr || reset);
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        assert (got === want) else
            abort_run($sformatf("FAIL t=%0t: %s is %b, expected %b", $time, name, got, want));
    endtask

    // Setup then access phase over two falling edges
    task automatic apb_transfer(input logic write, input logic [8:0] addr,
                                input logic [31:0] wdata);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(negedge clk);
        apb_req.penable = 1'b1;
        #2;
        obs_q.push_back(apb_obs_t'({write, addr, apb_rsp.prdata, apb_rsp.pslverr,
                                    apb_rsp.pready}));
        -> obs_ready;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic read_all();
        apb_transfer(1'b0, REG_CTRL, '0);
        apb_transfer(1'b0, REG_LINK, '0);
        for (int i = 0; i < NUM_LANES; i++) begin
            apb_transfer(1'b0, REG_LANE_BASE + 9'(i) * REG_LANE_STRIDE + REG_FRAMES, '0);
            apb_transfer(1'b0, REG_LANE_BASE + 9'(i) * REG_LANE_STRIDE + REG_ERRORS, '0);
            apb_transfer(1'b0, REG_LANE_BASE + 9'(i) * REG_LANE_STRIDE + REG_DROPS, '0);
        end
    endtask

    function automatic xgmii_word_t random_word();
        xgmii_word_t w;
        int unsigned kind;
        int unsigned pos;
        kind = $urandom_range(0, 7);
        w.d  = {$urandom(), $urandom()};
        w.c  = 8'h00;
        // Flagged start in byte 0 or 4 or in a misplaced byte
        if ((kind < 3) || (kind == 7)) begin
            pos = (kind < 2) ? 4 * kind : $urandom_range(0, 7);
            w.c[pos] = 1'b1;
            w.d[8*pos +: 8] = XGMII_START;
        end
        // Start value as plain data
        if (kind == 3) w.d[7:0] = XGMII_START;
        if (kind >= 5) begin
            repeat ($urandom_range(1, 3)) begin
                pos = $urandom_range(0, 7);
                w.c[pos] = 1'b1;
                w.d[8*pos +: 8] = XGMII_ERROR;
            end
        end
        return w;
    endfunction

    // Random words and block lock flips per cycle, then idle
    task automatic run_cycles(input int n, input bit traffic, input bit walk);
        repeat (n) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                rx_word[i] = traffic ? random_word() : IDLE_WORD;
                if (walk && ($urandom_range(0, 15) == 0)) block_lock[i] = !block_lock[i];
            end
            @(negedge clk);
        end
        rx_word = {NUM_LANES{IDLE_WORD}};
    endtask

    initial begin
        apb_obs_t obs;
        apb_exp_t want;
        forever begin
            @(obs_ready);
            while (obs_q.size() > 0) begin
                obs  = obs_q.pop_front();
                want = expected_read(obs.addr);
                if (obs.write) want.err = (obs.addr != REG_CTRL);
                assert (obs.ready) else
                    abort_run($sformatf("FAIL t=%0t: pready low in the access cycle at 0x%03h",
                                        $time, obs.addr));
                assert (obs.slverr == want.err) else
                    abort_run($sformatf("FAIL t=%0t: pslverr %b at 0x%03h, expected %b",
                                        $time, obs.slverr, obs.addr, want.err));
                assert (obs.write || want.err || (obs.data == want.data)) else
                    abort_run($sformatf("FAIL t=%0t: read 0x%03h got 0x%0h, expected 0x%0h",
                                        $time, obs.addr, obs.data, want.data));
            end
        end
    end

    // Test length plus half again at 8 ns per cycle
    initial begin
        #(TEST_CYCLES * 12);
        abort_run($sformatf("Watchdog expired at %0t before the tests completed", $time));
    end

    initial begin
        int waited;
        void'($urandom(32'h3402f520));
        reset      = 1'b1;
        rx_word    = {NUM_LANES{IDLE_WORD}};
        block_lock = '0;
        apb_req    = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_bit("qsfp_led_act", qsfp_led_act, 1'b0);
        check_bit("qsfp_led_stat_g", qsfp_led_stat_g, 1'b0);
        check_bit("qsfp_led_stat_y", qsfp_led_stat_y, 1'b0);
        read_all();

        run_cycles(WORDS, 1'b1, 1'b0);
        read_all();
        check_bit("qsfp_led_stat_y", qsfp_led_stat_y, exp_errors.or() != 0);

        // Activity LED after one start on lane 2 in byte 4
        run_cycles(ACT_HOLD + 3, 1'b0, 1'b0);
        check_bit("qsfp_led_act", qsfp_led_act, 1'b0);
        rx_word[2].d[39:32] = XGMII_START;
        @(negedge clk);
        rx_word = {NUM_LANES{IDLE_WORD}};
        waited = 0;
        while (!qsfp_led_act && (waited < ACT_HOLD)) begin
            @(negedge clk);
            waited++;
        end
        assert (qsfp_led_act) else
            abort_run($sformatf("FAIL t=%0t: qsfp_led_act still low %0d cycles after a start",
                                $time, waited));
        run_cycles(ACT_HOLD + 3, 1'b0, 1'b0);
        check_bit("qsfp_led_act", qsfp_led_act, 1'b0);

        // Lock runs one cycle short of qualifying
        repeat (3) begin
            block_lock = '1;
            run_cycles(LOCK_CYCLES - 3, 1'b0, 1'b0);
            // Last two lock edges fall inside the read
            apb_transfer(1'b0, REG_LINK, '0);
            block_lock = '0;
            run_cycles(1, 1'b0, 1'b0);
            check_bit("qsfp_led_stat_g", qsfp_led_stat_g, 1'b0);
            run_cycles(1, 1'b0, 1'b0);
        end
        block_lock = '1;
        run_cycles(LOCK_CYCLES - 1, 1'b0, 1'b0);
        // Read sampled right after the qualifying edge
        apb_transfer(1'b0, REG_LINK, '0);
        check_bit("qsfp_led_stat_g", qsfp_led_stat_g, 1'b1);
        block_lock[1] = 1'b0;
        run_cycles(2, 1'b0, 1'b0);
        check_bit("qsfp_led_stat_g", qsfp_led_stat_g, 1'b0);
        apb_transfer(1'b0, REG_LANE_BASE + REG_LANE_STRIDE + REG_DROPS, '0);
        run_cycles(WALK, 1'b0, 1'b1);
        read_all();
        check_bit("qsfp_led_stat_g", qsfp_led_stat_g, exp_link.and());

        // Bit 0 low leaves the counters alone and bit 0 high clears them
        apb_transfer(1'b1, REG_CTRL, 32'h0);
        read_all();
        apb_transfer(1'b1, REG_CTRL, 32'h1);
        read_all();
        check_bit("qsfp_led_stat_y", qsfp_led_stat_y, 1'b0);
        run_cycles(WORDS / 4, 1'b1, 1'b0);
        read_all();

        for (int k = 0; k < 6; k++) begin
            apb_transfer(1'b0, BAD_ADDR[k], '0);
            apb_transfer(1'b1, BAD_ADDR[k], 32'h1);
        end
        apb_transfer(1'b1, REG_LINK, 32'h1);
        apb_transfer(1'b1, REG_LANE_BASE + REG_ERRORS, 32'h1);
        read_all();

        run_cycles(2, 1'b0, 1'b0);
        if (obs_q.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("Some APB responses were never compared");
        end
    end

endmodule

// File: files.f
+incdir+tests
src/xgmii_pkg.sv
src/qsfp_status_pkg.sv
src/xgmii_frame_monitor.sv
src/link_health.sv
src/qsfp_status_regs.sv
src/qsfp_status_core.sv
tests/tb_qsfp_status_core.sv

// File: Makefile
VERILATOR  := verilator
TOP        := tb_qsfp_status_core
FILELIST   := files.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
